// File: files.f
+incdir+rtl
rtl/cache_pkg.sv
rtl/mem_bus_pkg.sv
rtl/refill_buffer.sv
rtl/tag_store.sv
rtl/line_store.sv
rtl/cache_ctrl.sv
rtl/cache_top.sv
tests/cache_checker.sv
tests/cache_tb.sv

// File: rtl/cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// cache geometry
// 2 ways x 128 sets x 32-byte lines = 8 KiB

// associativity
`define CACHE_WAY_NUM      2

// address split as tag | index | byte offset
`define CACHE_INDEX_WIDTH  7
`define CACHE_TAG_WIDTH    20
`define CACHE_OFFSET_WIDTH 5

// 32-bit words per line
`define CACHE_LINE_WORDS   8

`endif

// File: rtl/cache_ctrl.sv
`timescale 1ns/10ps

module cache_ctrl (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     valid,
    input  cache_pkg::cpu_req_t      req,
    output logic                     addr_ok,
    output logic                     data_ok,
    output logic                     rd_req,
    output mem_bus_pkg::mem_rd_req_t rd,
    input  logic                     rd_rdy,
    input  logic                     ret_valid,
    input  logic                     ret_last,
    output logic                     wr_req,
    output mem_bus_pkg::mem_wr_req_t wr,
    input  logic                     wr_rdy,
    output cache_pkg::cpu_req_t      cur_req,
    input  logic                     hit,
    input  cache_pkg::way_t          hit_way,
    output cache_pkg::way_t          victim_way,
    input  cache_pkg::tag_t          victim_tag,
    input  logic                     victim_dirty,
    input  cache_pkg::line_t         victim_line,
    output logic                     fill_we,
    output logic                     hit_we
);
    import cache_pkg::*;
    import mem_bus_pkg::*;

    main_state_t state;
    main_state_t state_nx;
    way_t        rr_way;
    logic        rd_sent;
    logic        wr_ok_q;
    logic        ret_done;
    logic        is_write;
    logic        need_wr;

    assign addr_ok  = (state == idle);
    assign is_write = (cur_req.op == op_write);
    assign ret_done = ret_valid && ret_last;

    // uncached writes and dirty victims go out through the write port first
    assign need_wr  = cur_req.uncached ? is_write : victim_dirty;

    always_ff @(posedge clk) begin
        if (valid && addr_ok) begin
            cur_req <= req;
        end
    end

    always_comb begin
        state_nx = state;
        case (state)
            idle: begin
                if (valid) begin
                    state_nx = lookup;
                end
            end
            lookup: state_nx = hit ? idle : miss;
            miss: begin
                if (!need_wr) begin
                    state_nx = refill;
                end else if (wr_rdy) begin
                    state_nx = replace;
                end
            end
            replace: state_nx = cur_req.uncached ? idle : refill;
            refill: begin
                if (ret_done) begin
                    state_nx = idle;
                end
            end
            default: state_nx = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state   <= idle;
            rr_way  <= '0;
            rd_sent <= 1'b0;
            wr_ok_q <= 1'b0;
        end else begin
            state   <= state_nx;
            // writes complete toward the cpu one cycle after acceptance
            wr_ok_q <= valid && addr_ok && (req.op == op_write);
            if (state != refill) begin
                rd_sent <= 1'b0;
            end else if (rd_req && rd_rdy) begin
                rd_sent <= 1'b1;
            end
            if (fill_we) begin
                rr_way <= rr_way + 1'b1;
            end
        end
    end

    // way select for array writes, the hit way on a hit
    assign victim_way = hit ? hit_way : rr_way;

    assign hit_we  = (state == lookup) && hit && is_write;
    assign fill_we = (state == refill) && ret_done && !cur_req.uncached;
    assign rd_req  = (state == refill) && !rd_sent;
    assign wr_req  = (state == replace);
    assign data_ok = wr_ok_q || (!is_write && (((state == lookup) && hit) ||
                                               ((state == refill) && ret_done)));

    assign rd.rd_type = cur_req.uncached ? {1'b0, cur_req.size} : XFER_LINE;
    assign rd.rd_addr = {cur_req.tag, cur_req.index,
                         cur_req.uncached ? cur_req.offset : offset_t'(0)};

    assign wr.wr_type  = cur_req.uncached ? {1'b0, cur_req.size} : XFER_LINE;
    assign wr.wr_addr  = cur_req.uncached ? {cur_req.tag, cur_req.index, cur_req.offset}
                                          : {victim_tag, cur_req.index, offset_t'(0)};
    assign wr.wr_wstrb = cur_req.uncached ? cur_req.wstrb : 4'b1111;
    assign wr.wr_data  = cur_req.uncached ? line_t'(cur_req.wdata) : victim_line;

endmodule

// File: rtl/cache_pkg.sv
`include "cache_cfg.svh"

package cache_pkg;

    // address fields
    typedef logic [`CACHE_TAG_WIDTH-1:0]           tag_t;
    typedef logic [`CACHE_INDEX_WIDTH-1:0]         index_t;
    typedef logic [`CACHE_OFFSET_WIDTH-1:0]        offset_t;
    typedef logic [$clog2(`CACHE_LINE_WORDS)-1:0]  word_sel_t;
    typedef logic [$clog2(`CACHE_WAY_NUM)-1:0]     way_t;

    // data
    typedef logic [31:0]                           word_t;
    typedef logic [`CACHE_LINE_WORDS*32-1:0]       line_t;
    typedef logic [`CACHE_LINE_WORDS*4-1:0]        line_strb_t;

    typedef enum logic [2:0] {idle, lookup, miss, replace, refill} main_state_t;

    // processor request, held until the transaction ends
    typedef struct packed {
        logic       op;
        tag_t       tag;
        index_t     index;
        offset_t    offset;
        logic [3:0] wstrb;
        word_t      wdata;
        logic       uncached;
        logic [1:0] size;
    } cpu_req_t;

endpackage

// File: rtl/cache_top.sv
`timescale 1ns/10ps

module cache_top (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     valid,
    input  cache_pkg::cpu_req_t      req,
    output logic                     addr_ok,
    output logic                     data_ok,
    output cache_pkg::word_t         rdata,
    output logic                     rd_req,
    output mem_bus_pkg::mem_rd_req_t rd,
    input  logic                     rd_rdy,
    input  logic                     ret_valid,
    input  logic                     ret_last,
    input  cache_pkg::word_t         ret_data,
    output logic                     wr_req,
    output mem_bus_pkg::mem_wr_req_t wr,
    input  logic                     wr_rdy
);
    import cache_pkg::*;

    cpu_req_t cur_req;
    logic     hit;
    way_t     hit_way;
    way_t     victim_way;
    tag_t     victim_tag;
    logic     victim_dirty;
    line_t    victim_line;
    line_t    fill_line;
    logic     fill_we;
    logic     hit_we;

    // arrays read the incoming set on the accepting edge
    wire      accept = valid && addr_ok;

    cache_ctrl u_ctrl (.*);

    tag_store u_tag_store (
        .lookup_index (req.index),
        .*
    );

    line_store u_line_store (
        .lookup_index (req.index),
        .*
    );

    refill_buffer u_refill_buffer (.*);

endmodule

// File: rtl/line_store.sv
`timescale 1ns/10ps
`include "cache_cfg.svh"

module line_store (
    input  logic                clk,
    input  cache_pkg::index_t   lookup_index,
    input  logic                accept,
    input  cache_pkg::cpu_req_t cur_req,
    input  logic                hit,
    input  cache_pkg::way_t     hit_way,
    input  cache_pkg::way_t     victim_way,
    input  logic                fill_we,
    input  logic                hit_we,
    input  cache_pkg::line_t    fill_line,
    input  cache_pkg::word_t    ret_data,
    output cache_pkg::line_t    victim_line,
    output cache_pkg::word_t    rdata
);
    import cache_pkg::*;
    import mem_bus_pkg::*;

    localparam int SETS = 1 << `CACHE_INDEX_WIDTH;

    line_t      line_mem [`CACHE_WAY_NUM][SETS];
    line_t      set_line [`CACHE_WAY_NUM];
    word_sel_t  word_sel;
    line_strb_t byte_en;
    line_t      base_line;
    line_t      merged_line;
    line_t      src_line;

    assign word_sel = cur_req.offset[`CACHE_OFFSET_WIDTH-1:2];

    // write strobes moved to the addressed word, none for a read fill
    assign byte_en = (cur_req.op == op_write) ?
                     (line_strb_t'(cur_req.wstrb) << {word_sel, 2'b00}) : '0;

    assign base_line = fill_we ? fill_line : set_line[victim_way];

    always_comb begin
        for (int b = 0; b < `CACHE_LINE_WORDS*4; b++) begin
            merged_line[b*8 +: 8] = byte_en[b] ? cur_req.wdata[(b%4)*8 +: 8]
                                               : base_line[b*8 +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (fill_we || hit_we) begin
            line_mem[victim_way][cur_req.index] <= merged_line;
        end
        if (accept) begin
            for (int w = 0; w < `CACHE_WAY_NUM; w++) begin
                set_line[w] <= line_mem[w][lookup_index];
            end
        end
    end

    assign victim_line = set_line[victim_way];

    // hit data in lookup, refill data on the last returned word
    assign src_line = hit ? set_line[hit_way] : fill_line;
    assign rdata    = cur_req.uncached ? ret_data : src_line[word_sel*32 +: 32];

endmodule

// File: rtl/mem_bus_pkg.sv
package mem_bus_pkg;

    import cache_pkg::*;

    // whole-line transfer type
    localparam logic [2:0] XFER_LINE = 3'b100;

    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } op_e;

    typedef struct packed {
        logic [2:0]  rd_type;
        logic [31:0] rd_addr;
    } mem_rd_req_t;

    // wr_data only carries the low word for a single-word write
    typedef struct packed {
        logic [2:0]  wr_type;
        logic [31:0] wr_addr;
        logic [3:0]  wr_wstrb;
        line_t       wr_data;
    } mem_wr_req_t;

endpackage

// File: rtl/refill_buffer.sv
`timescale 1ns/10ps

module refill_buffer (
    input  logic             clk,
    input  logic             resetn,
    input  logic             ret_valid,
    input  logic             ret_last,
    input  cache_pkg::word_t ret_data,
    output cache_pkg::line_t fill_line
);
    import cache_pkg::*;

    word_sel_t word_cnt;
    line_t     line_q;

    // current word is merged in directly so the line is complete on ret_last
    always_comb begin
        fill_line = line_q;
        if (ret_valid) begin
            fill_line[word_cnt*32 +: 32] = ret_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn || (ret_valid && ret_last)) begin
            word_cnt <= '0;
            line_q   <= '0;
        end else if (ret_valid) begin
            word_cnt <= word_cnt + 1'b1;
            line_q   <= fill_line;
        end
    end

endmodule

// File: rtl/tag_store.sv
`timescale 1ns/10ps
`include "cache_cfg.svh"

module tag_store (
    input  logic                clk,
    input  logic                resetn,
    input  cache_pkg::index_t   lookup_index,
    input  logic                accept,
    input  cache_pkg::cpu_req_t cur_req,
    input  cache_pkg::way_t     victim_way,
    input  logic                fill_we,
    input  logic                hit_we,
    output cache_pkg::way_t     hit_way,
    output logic                hit,
    output cache_pkg::tag_t     victim_tag,
    output logic                victim_dirty
);
    import cache_pkg::*;
    import mem_bus_pkg::*;

    localparam int SETS = 1 << `CACHE_INDEX_WIDTH;

    tag_t                      tag_mem   [`CACHE_WAY_NUM][SETS];
    logic [SETS-1:0]           valid_mem [`CACHE_WAY_NUM];
    logic [SETS-1:0]           dirty_mem [`CACHE_WAY_NUM];

    // registered copy of the addressed set
    tag_t                      set_tag   [`CACHE_WAY_NUM];
    logic [`CACHE_WAY_NUM-1:0] set_valid;
    logic [`CACHE_WAY_NUM-1:0] set_dirty;
    logic [`CACHE_WAY_NUM-1:0] way_hit;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int w = 0; w < `CACHE_WAY_NUM; w++) begin
                valid_mem[w] <= '0;
            end
        end else if (fill_we) begin
            valid_mem[victim_way][cur_req.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_we) begin
            tag_mem[victim_way][cur_req.index]   <= cur_req.tag;
            dirty_mem[victim_way][cur_req.index] <= (cur_req.op == op_write);
        end else if (hit_we) begin
            dirty_mem[victim_way][cur_req.index] <= 1'b1;
        end
        if (accept) begin
            for (int w = 0; w < `CACHE_WAY_NUM; w++) begin
                set_tag[w]   <= tag_mem[w][lookup_index];
                set_valid[w] <= valid_mem[w][lookup_index];
                set_dirty[w] <= dirty_mem[w][lookup_index];
            end
        end
    end

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `CACHE_WAY_NUM; w++) begin
            way_hit[w] = set_valid[w] && (set_tag[w] == cur_req.tag);
            if (way_hit[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    // uncached accesses never hit
    assign hit          = (|way_hit) && !cur_req.uncached;
    assign victim_tag   = set_tag[victim_way];
    assign victim_dirty = set_valid[victim_way] && set_dirty[victim_way];

endmodule

// File: tests/cache_checker.sv
`timescale 1ns/10ps

module cache_checker (
    input logic                     clk,
    input logic                     resetn,
    input logic                     valid,
    input cache_pkg::cpu_req_t      req,
    input logic                     addr_ok,
    input logic                     data_ok,
    input logic                     rd_req,
    input mem_bus_pkg::mem_rd_req_t rd,
    input logic                     rd_rdy,
    input logic                     wr_req,
    input logic                     wr_rdy
);
    import mem_bus_pkg::*;

    int error_count;

    initial error_count = 0;

    // idle outputs in every cycle that follows a reset cycle
    reset_idle: assert property (@(posedge clk)
        !resetn |=> addr_ok && !rd_req && !wr_req && !data_ok)
        else begin
            error_count++;
            $error("outputs not idle after reset");
        end

    // read request held with a stable payload until rd_rdy
    rd_hold: assert property (@(posedge clk) disable iff (!resetn)
        rd_req && !rd_rdy |=> rd_req && $stable(rd))
        else begin
            error_count++;
            $error("rd_req dropped or changed before rd_rdy");
        end

    rd_drop: assert property (@(posedge clk) disable iff (!resetn)
        rd_req && rd_rdy |=> !rd_req)
        else begin
            error_count++;
            $error("rd_req still high after the read was taken");
        end

    // write request only after memory was ready, and for one cycle
    wr_rise: assert property (@(posedge clk) disable iff (!resetn)
        $rose(wr_req) |-> $past(wr_rdy))
        else begin
            error_count++;
            $error("wr_req rose while wr_rdy was low");
        end

    wr_pulse: assert property (@(posedge clk) disable iff (!resetn)
        wr_req |=> !wr_req)
        else begin
            error_count++;
            $error("wr_req longer than one cycle");
        end

    accept_leave: assert property (@(posedge clk) disable iff (!resetn)
        valid && addr_ok |=> !addr_ok)
        else begin
            error_count++;
            $error("addr_ok still high after a request was accepted");
        end

    write_ack: assert property (@(posedge clk) disable iff (!resetn)
        valid && addr_ok && (req.op == op_write) |=> data_ok)
        else begin
            error_count++;
            $error("write not acknowledged one cycle after acceptance");
        end

endmodule

// File: tests/cache_tb.sv
`timescale 1ns/10ps
`include "cache_cfg.svh"

module cache_tb;
    import cache_pkg::*;
    import mem_bus_pkg::*;

    localparam int MEM_WORDS = 16384;
    localparam int TIMEOUT   = 200;

    logic        clk;
    logic        resetn;
    logic        valid;
    cpu_req_t    req;
    logic        addr_ok;
    logic        data_ok;
    word_t       rdata;
    logic        rd_req;
    mem_rd_req_t rd;
    logic        rd_rdy;
    logic        ret_valid;
    logic        ret_last;
    word_t       ret_data;
    logic        wr_req;
    mem_wr_req_t wr;
    logic        wr_rdy;

    // memory contents and the expected view of them
    word_t       mem    [MEM_WORDS];
    word_t       shadow [MEM_WORDS];
    logic [31:0] rng;
    int          rd_wait;
    int          ret_left;
    int          ret_wait;
    int          ret_ptr;
    int          rd_count;
    int          wr_count;
    mem_rd_req_t last_rd;
    mem_wr_req_t last_wr;

    cache_top i_dut (.*);

    bind cache_top cache_checker i_checker (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // hash of the full byte address
    function automatic word_t fill_word(input logic [31:0] a);
        return (a * 32'h9e37_79b9) ^ {a[15:0], ~a[15:0]};
    endfunction

    function automatic word_t merge_bytes(input word_t old, input word_t data,
                                          input logic [3:0] strb);
        word_t w;
        w = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                w[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        return w;
    endfunction

    task automatic abort_run();
        $display("Something failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic stop_with(input string why);
        $display("%s at %0t ns", why, $time);
        abort_run();
    endtask

    task automatic expect_eq(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic poll_checker();
        if (i_dut.i_checker.error_count != 0) begin
            stop_with("a port timing assertion failed");
        end
    endtask

    // memory side of a write, line write-backs must match the expected line
    task automatic take_write();
        int base;
        base = wr.wr_addr[15:2];
        wr_count++;
        last_wr = wr;
        if (wr.wr_type == XFER_LINE) begin
            for (int w = 0; w < `CACHE_LINE_WORDS; w++) begin
                expect_eq("wr.wr_data", wr.wr_data[w*32 +: 32], shadow[base + w]);
                mem[base + w] = wr.wr_data[w*32 +: 32];
            end
        end else begin
            mem[base] = merge_bytes(mem[base], wr.wr_data[31:0], wr.wr_wstrb);
        end
    endtask

    // memory model, random ready and return gaps
    always @(negedge clk) begin
        if (resetn) begin
            rng    = xorshift(rng);
            wr_rdy = (rng[1:0] != 2'b00);
            if (wr_req) begin
                take_write();
            end
            ret_valid = 1'b0;
            ret_last  = 1'b0;
            if (ret_left > 0) begin
                if (ret_wait > 0) begin
                    ret_wait--;
                end else begin
                    ret_valid = 1'b1;
                    ret_last  = (ret_left == 1);
                    ret_data  = mem[ret_ptr];
                    ret_ptr++;
                    ret_left--;
                    rng       = xorshift(rng);
                    ret_wait  = rng % 3;
                end
            end
            if (rd_rdy) begin
                rd_rdy = 1'b0;
            end else if (rd_req && ret_left == 0) begin
                if (rd_wait > 0) begin
                    rd_wait--;
                end else begin
                    rd_rdy   = 1'b1;
                    rd_count++;
                    last_rd  = rd;
                    ret_ptr  = rd.rd_addr[15:2];
                    ret_left = (rd.rd_type == XFER_LINE) ? `CACHE_LINE_WORDS : 1;
                    rng      = xorshift(rng);
                    rd_wait  = rng % 4;
                    ret_wait = rng[5:4];
                end
            end
        end
    end

    // one request, ends when addr_ok returns
    task automatic cpu_access(input logic is_wr, input logic [31:0] addr,
                              input logic [3:0] strb, input word_t data,
                              input logic unc, input logic [1:0] size,
                              output word_t got, output int lat);
        int   cycles;
        logic done;
        @(negedge clk);
        valid        = 1'b1;
        req.op       = is_wr;
        req.tag      = addr[31:12];
        req.index    = addr[11:5];
        req.offset   = addr[4:0];
        req.wstrb    = strb;
        req.wdata    = data;
        req.uncached = unc;
        req.size     = size;
        @(posedge clk);
        expect_eq("addr_ok", addr_ok, 1'b1);
        @(negedge clk);
        valid  = 1'b0;
        got    = '0;
        lat    = 0;
        cycles = 0;
        done   = 1'b0;
        while (!done) begin
            @(posedge clk);
            cycles++;
            poll_checker();
            if (data_ok && lat == 0) begin
                lat = cycles;
                got = rdata;
            end
            if (addr_ok) begin
                done = 1'b1;
            end else if (cycles > TIMEOUT) begin
                stop_with("request did not complete in time");
            end
        end
        if (lat == 0) begin
            stop_with("request ended without data_ok");
        end
    endtask

    task automatic read_word(input logic [31:0] addr, input logic unc,
                             input logic [1:0] size, output int lat);
        word_t got;
        cpu_access(1'b0, addr, 4'b0000, '0, unc, size, got, lat);
        expect_eq("rdata", got, shadow[addr[15:2]]);
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [3:0] strb,
                              input word_t data, input logic unc, input logic [1:0] size);
        word_t got;
        int    lat;
        shadow[addr[15:2]] = merge_bytes(shadow[addr[15:2]], data, strb);
        cpu_access(1'b1, addr, strb, data, unc, size, got, lat);
        expect_eq("write data_ok latency", lat, 1);
    endtask

    initial begin
        int lat;
        int rd_base;
        int wr_base;
        clk       = 1'b0;
        resetn    = 1'b0;
        valid     = 1'b0;
        req       = '0;
        rd_rdy    = 1'b0;
        wr_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        rng       = 32'h4537_f3b1;
        rd_wait   = 2;
        ret_left  = 0;
        ret_wait  = 0;
        ret_ptr   = 0;
        rd_count  = 0;
        wr_count  = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i]    = fill_word(i * 4);
            shadow[i] = mem[i];
        end
        repeat (5) @(negedge clk);
        resetn = 1'b1;

        // line fill on a read miss, then a hit in the same line
        rd_base = rd_count;
        read_word(32'h0000_1048, 1'b0, 2'b10, lat);
        expect_eq("line read count", rd_count - rd_base, 1);
        expect_eq("rd.rd_type", last_rd.rd_type, XFER_LINE);
        expect_eq("rd.rd_addr", last_rd.rd_addr, 32'h0000_1040);
        read_word(32'h0000_105c, 1'b0, 2'b10, lat);
        expect_eq("read hit latency", lat, 1);
        expect_eq("line read count", rd_count - rd_base, 1);

        // partial write hit merged into the line
        write_word(32'h0000_1044, 4'b0110, 32'hdead_beef, 1'b0, 2'b10);
        read_word(32'h0000_1044, 1'b0, 2'b10, lat);
        expect_eq("read hit latency", lat, 1);
        expect_eq("line read count", rd_count - rd_base, 1);

        // three tags on index 5, the written one gets evicted
        wr_base = wr_count;
        write_word(32'h0000_20a4, 4'b1001, 32'h1357_9bdf, 1'b0, 2'b10);
        read_word(32'h0000_30a0, 1'b0, 2'b10, lat);
        expect_eq("line write count", wr_count - wr_base, 0);
        read_word(32'h0000_40a8, 1'b0, 2'b10, lat);
        expect_eq("line write count", wr_count - wr_base, 1);
        expect_eq("wr.wr_type", last_wr.wr_type, XFER_LINE);
        expect_eq("wr.wr_addr", last_wr.wr_addr, 32'h0000_20a0);
        rd_base = rd_count;
        read_word(32'h0000_20a4, 1'b0, 2'b10, lat);
        expect_eq("line read count", rd_count - rd_base, 1);
        expect_eq("line write count", wr_count - wr_base, 1);

        // uncached word transfers bypass the arrays
        rd_base = rd_count;
        wr_base = wr_count;
        read_word(32'h0000_5126, 1'b1, 2'b01, lat);
        expect_eq("word read count", rd_count - rd_base, 1);
        expect_eq("rd.rd_type", last_rd.rd_type, 3'b001);
        expect_eq("rd.rd_addr", last_rd.rd_addr, 32'h0000_5126);
        write_word(32'h0000_6133, 4'b1000, 32'hab00_0000, 1'b1, 2'b00);
        expect_eq("word write count", wr_count - wr_base, 1);
        expect_eq("wr.wr_type", last_wr.wr_type, 3'b000);
        expect_eq("wr.wr_addr", last_wr.wr_addr, 32'h0000_6133);
        expect_eq("wr.wr_wstrb", last_wr.wr_wstrb, 4'b1000);
        expect_eq("wr.wr_data", last_wr.wr_data[31:0], 32'hab00_0000);
        read_word(32'h0000_5120, 1'b0, 2'b10, lat);
        expect_eq("line read count", rd_count - rd_base, 2);
        expect_eq("rd.rd_type", last_rd.rd_type, XFER_LINE);
        expect_eq("rd.rd_addr", last_rd.rd_addr, 32'h0000_5120);
        read_word(32'h0000_6130, 1'b0, 2'b10, lat);
        expect_eq("line read count", rd_count - rd_base, 3);
        expect_eq("rd.rd_addr", last_rd.rd_addr, 32'h0000_6120);

        repeat (2) @(posedge clk);
        if (i_dut.i_checker.error_count == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            stop_with("a port timing assertion failed");
        end
    end

endmodule
